// ==== hdl/dpr_pkg.sv ====
package dpr_pkg;

  // Operand and result width
  localparam int DATA_W = 8;

  // Opcode width, matches the five bit op select
  localparam int OP_W = 5;

  // Input buffer depth, also the sender's credits after reset
  localparam int CREDITS = 4;

  localparam int PTR_W = $clog2(CREDITS);
  localparam int CNT_W = $clog2(CREDITS + 1);

  // Shift amounts at or above this give zero
  localparam logic [DATA_W-1:0] SHIFT_LIMIT = DATA_W'(DATA_W);

  typedef enum logic [OP_W-1:0] {
    OP_ADD = 0,
    OP_DEC = 1,
    OP_DIV = 2,
    OP_INC = 3,
    OP_MOD = 4,
    OP_MUL = 5,
    OP_MUX = 6,
    OP_REG = 7,
    OP_SHL = 8,
    OP_SHR = 9,
    OP_SUB = 10
  } alu_op_e;

  typedef enum logic [1:0] {
    COUPLED,
    DRAINING,
    DECOUPLED
  } dcpl_state_e;

endpackage

// ==== hdl/op_fifo.sv ====
`timescale 1ns/1ps

module op_fifo (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic                        in_valid_i,
  input  dpr_pkg::alu_op_e            in_op_i,
  input  logic [dpr_pkg::DATA_W-1:0]  in_a_i,
  input  logic [dpr_pkg::DATA_W-1:0]  in_b_i,
  input  logic                        in_mux_sel_i,
  input  logic                        issue_i,
  output dpr_pkg::alu_op_e            head_op_o,
  output logic [dpr_pkg::DATA_W-1:0]  head_a_o,
  output logic [dpr_pkg::DATA_W-1:0]  head_b_o,
  output logic                        head_mux_sel_o,
  output logic                        nonempty_o
);
  import dpr_pkg::*;

  alu_op_e           op_mem  [CREDITS];
  logic [DATA_W-1:0] a_mem   [CREDITS];
  logic [DATA_W-1:0] b_mem   [CREDITS];
  logic              sel_mem [CREDITS];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(CREDITS - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  always_ff @(posedge clk) begin
    if (in_valid_i) begin
      op_mem[wr_ptr_q]  <= in_op_i;
      a_mem[wr_ptr_q]   <= in_a_i;
      b_mem[wr_ptr_q]   <= in_b_i;
      sel_mem[wr_ptr_q] <= in_mux_sel_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (in_valid_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (issue_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({in_valid_i, issue_i})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  assign head_op_o      = op_mem[rd_ptr_q];
  assign head_a_o       = a_mem[rd_ptr_q];
  assign head_b_o       = b_mem[rd_ptr_q];
  assign head_mux_sel_o = sel_mem[rd_ptr_q];
  assign nonempty_o     = (count_q != '0);

  // Sender must hold a credit, so a full buffer never sees a write
  a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n_i)
    in_valid_i |-> (count_q != CNT_W'(CREDITS)));

  // Decoupler only issues against a valid head
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
    issue_i |-> (count_q != '0));

endmodule

// ==== hdl/arith_unit.sv ====
`timescale 1ns/1ps

module arith_unit (
  input  logic [dpr_pkg::DATA_W-1:0] a_i,
  input  logic [dpr_pkg::DATA_W-1:0] b_i,
  output logic [dpr_pkg::DATA_W-1:0] add_o,
  output logic [dpr_pkg::DATA_W-1:0] sub_o,
  output logic [dpr_pkg::DATA_W-1:0] inc_o,
  output logic [dpr_pkg::DATA_W-1:0] dec_o,
  output logic [dpr_pkg::DATA_W-1:0] mul_o,
  output logic [dpr_pkg::DATA_W-1:0] div_o,
  output logic [dpr_pkg::DATA_W-1:0] mod_o
);
  import dpr_pkg::*;

  logic b_zero;

  assign b_zero = (b_i == '0);

  // Wrapping add and subtract
  assign add_o = a_i + b_i;
  assign sub_o = a_i - b_i;

  assign inc_o = a_i + DATA_W'(1);
  assign dec_o = a_i - DATA_W'(1);

  // Low half of the product only
  assign mul_o = a_i * b_i;

  // Divide by zero saturates to all ones
  assign div_o = b_zero ? '1 : a_i / b_i;

  // Modulo by zero passes a through
  assign mod_o = b_zero ? a_i : a_i % b_i;

endmodule

// ==== hdl/shift_select_unit.sv ====
`timescale 1ns/1ps

module shift_select_unit (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic [dpr_pkg::DATA_W-1:0] a_i,
  input  logic [dpr_pkg::DATA_W-1:0] b_i,
  input  logic                       mux_sel_i,
  input  dpr_pkg::alu_op_e           op_i,
  input  logic                       issue_i,
  output logic [dpr_pkg::DATA_W-1:0] shl_o,
  output logic [dpr_pkg::DATA_W-1:0] shr_o,
  output logic [dpr_pkg::DATA_W-1:0] mux_o,
  output logic [dpr_pkg::DATA_W-1:0] reg_o
);
  import dpr_pkg::*;

  logic              over_range;
  logic [DATA_W-1:0] hold_q;

  // Shift amount taken from b
  assign over_range = (b_i >= SHIFT_LIMIT);

  assign shl_o = over_range ? '0 : (a_i << b_i);
  assign shr_o = over_range ? '0 : (a_i >> b_i);

  assign mux_o = mux_sel_i ? b_i : a_i;

  // Value seen before any load in this cycle
  assign reg_o = hold_q;

  // Held register follows the last issued mux item
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      hold_q <= '0;
    end else if (issue_i && (op_i == OP_MUX)) begin
      hold_q <= mux_o;
    end
  end

endmodule

// ==== hdl/rp_decoupler.sv ====
`timescale 1ns/1ps

module rp_decoupler (
  input  logic clk,
  input  logic rst_n_i,
  input  logic decouple_i,
  input  logic nonempty_i,
  input  logic res_valid_i,
  output logic issue_o,
  output logic decouple_status_o
);
  import dpr_pkg::*;

  dcpl_state_e state_q;
  dcpl_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      COUPLED: begin
        if (decouple_i) begin
          state_d = DRAINING;
        end
      end
      // Wait for the last issued result to leave
      DRAINING: begin
        if (!decouple_i) begin
          state_d = COUPLED;
        end else if (!res_valid_i) begin
          state_d = DECOUPLED;
        end
      end
      DECOUPLED: begin
        if (!decouple_i) begin
          state_d = COUPLED;
        end
      end
      default: state_d = COUPLED;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= COUPLED;
    end else begin
      state_q <= state_d;
    end
  end

  assign issue_o           = nonempty_i && (state_q == COUPLED);
  assign decouple_status_o = (state_q == DECOUPLED);

  a_issue_coupled: assert property (@(posedge clk) disable iff (!rst_n_i)
    (state_q != COUPLED) |-> !issue_o);

endmodule

// ==== hdl/result_stage.sv ====
`timescale 1ns/1ps

module result_stage (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       issue_i,
  input  dpr_pkg::alu_op_e           op_i,
  input  logic [dpr_pkg::DATA_W-1:0] a_i,
  input  logic [dpr_pkg::DATA_W-1:0] b_i,
  input  logic [dpr_pkg::DATA_W-1:0] add_i,
  input  logic [dpr_pkg::DATA_W-1:0] sub_i,
  input  logic [dpr_pkg::DATA_W-1:0] inc_i,
  input  logic [dpr_pkg::DATA_W-1:0] dec_i,
  input  logic [dpr_pkg::DATA_W-1:0] mul_i,
  input  logic [dpr_pkg::DATA_W-1:0] div_i,
  input  logic [dpr_pkg::DATA_W-1:0] mod_i,
  input  logic [dpr_pkg::DATA_W-1:0] shl_i,
  input  logic [dpr_pkg::DATA_W-1:0] shr_i,
  input  logic [dpr_pkg::DATA_W-1:0] mux_i,
  input  logic [dpr_pkg::DATA_W-1:0] reg_i,
  output logic                       res_valid_o,
  output logic [dpr_pkg::DATA_W-1:0] res_o,
  output logic                       comp_lt_o,
  output logic                       comp_gt_o,
  output logic                       comp_eq_o,
  output logic                       credit_o
);
  import dpr_pkg::*;

  logic [DATA_W-1:0] sel_res;
  logic              issue_q;

  always_comb begin
    case (op_i)
      OP_ADD:  sel_res = add_i;
      OP_DEC:  sel_res = dec_i;
      OP_DIV:  sel_res = div_i;
      OP_INC:  sel_res = inc_i;
      OP_MOD:  sel_res = mod_i;
      OP_MUL:  sel_res = mul_i;
      OP_MUX:  sel_res = mux_i;
      OP_REG:  sel_res = reg_i;
      OP_SHL:  sel_res = shl_i;
      OP_SHR:  sel_res = shr_i;
      OP_SUB:  sel_res = sub_i;
      default: sel_res = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      issue_q   <= 1'b0;
      res_o     <= '0;
      comp_lt_o <= 1'b0;
      comp_gt_o <= 1'b0;
      comp_eq_o <= 1'b0;
    end else begin
      issue_q <= issue_i;
      if (issue_i) begin
        res_o     <= sel_res;
        comp_lt_o <= (a_i < b_i);
        comp_gt_o <= (a_i > b_i);
        comp_eq_o <= (a_i == b_i);
      end
    end
  end

  // Each result frees one buffer slot
  assign res_valid_o = issue_q;
  assign credit_o    = issue_q;

endmodule

// ==== hdl/dpr_alu_top.sv ====
`timescale 1ns/1ps

module dpr_alu_top (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       in_valid_i,
  input  dpr_pkg::alu_op_e           in_op_i,
  input  logic [dpr_pkg::DATA_W-1:0] in_a_i,
  input  logic [dpr_pkg::DATA_W-1:0] in_b_i,
  input  logic                       in_mux_sel_i,
  input  logic                       decouple_i,
  output logic                       credit_o,
  output logic                       res_valid_o,
  output logic [dpr_pkg::DATA_W-1:0] res_o,
  output logic                       comp_lt_o,
  output logic                       comp_gt_o,
  output logic                       comp_eq_o,
  output logic                       decouple_status_o
);
  import dpr_pkg::*;

  alu_op_e           head_op;
  logic [DATA_W-1:0] head_a;
  logic [DATA_W-1:0] head_b;
  logic              head_mux_sel;
  logic              nonempty;
  logic              issue;

  logic [DATA_W-1:0] add_r;
  logic [DATA_W-1:0] sub_r;
  logic [DATA_W-1:0] inc_r;
  logic [DATA_W-1:0] dec_r;
  logic [DATA_W-1:0] mul_r;
  logic [DATA_W-1:0] div_r;
  logic [DATA_W-1:0] mod_r;
  logic [DATA_W-1:0] shl_r;
  logic [DATA_W-1:0] shr_r;
  logic [DATA_W-1:0] mux_r;
  logic [DATA_W-1:0] reg_r;

  op_fifo u_op_fifo (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .in_valid_i     (in_valid_i),
    .in_op_i        (in_op_i),
    .in_a_i         (in_a_i),
    .in_b_i         (in_b_i),
    .in_mux_sel_i   (in_mux_sel_i),
    .issue_i        (issue),
    .head_op_o      (head_op),
    .head_a_o       (head_a),
    .head_b_o       (head_b),
    .head_mux_sel_o (head_mux_sel),
    .nonempty_o     (nonempty)
  );

  arith_unit u_arith_unit (
    .a_i   (head_a),
    .b_i   (head_b),
    .add_o (add_r),
    .sub_o (sub_r),
    .inc_o (inc_r),
    .dec_o (dec_r),
    .mul_o (mul_r),
    .div_o (div_r),
    .mod_o (mod_r)
  );

  shift_select_unit u_shift_select_unit (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .a_i       (head_a),
    .b_i       (head_b),
    .mux_sel_i (head_mux_sel),
    .op_i      (head_op),
    .issue_i   (issue),
    .shl_o     (shl_r),
    .shr_o     (shr_r),
    .mux_o     (mux_r),
    .reg_o     (reg_r)
  );

  rp_decoupler u_rp_decoupler (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .decouple_i        (decouple_i),
    .nonempty_i        (nonempty),
    .res_valid_i       (res_valid_o),
    .issue_o           (issue),
    .decouple_status_o (decouple_status_o)
  );

  result_stage u_result_stage (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .issue_i     (issue),
    .op_i        (head_op),
    .a_i         (head_a),
    .b_i         (head_b),
    .add_i       (add_r),
    .sub_i       (sub_r),
    .inc_i       (inc_r),
    .dec_i       (dec_r),
    .mul_i       (mul_r),
    .div_i       (div_r),
    .mod_i       (mod_r),
    .shl_i       (shl_r),
    .shr_i       (shr_r),
    .mux_i       (mux_r),
    .reg_i       (reg_r),
    .res_valid_o (res_valid_o),
    .res_o       (res_o),
    .comp_lt_o   (comp_lt_o),
    .comp_gt_o   (comp_gt_o),
    .comp_eq_o   (comp_eq_o),
    .credit_o    (credit_o)
  );

endmodule

// ==== verification/alu_model.svh ====
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Expected result of one item, held is the last mux value sent before it
function automatic logic [DATA_W-1:0] expect_result(
  input logic [OP_W-1:0]   op,
  input logic [DATA_W-1:0] a,
  input logic [DATA_W-1:0] b,
  input logic              sel,
  input logic [DATA_W-1:0] held
);
  int ai;
  int bi;
  int r;
  ai = int'(a);
  bi = int'(b);
  case (op)
    OP_ADD:  r = ai + bi;
    OP_DEC:  r = ai - 1;
    OP_DIV:  r = (bi == 0) ? (1 << DATA_W) - 1 : ai / bi;
    OP_INC:  r = ai + 1;
    OP_MOD:  r = (bi == 0) ? ai : ai % bi;
    OP_MUL:  r = ai * bi;
    OP_MUX:  r = sel ? bi : ai;
    OP_REG:  r = int'(held);
    OP_SHL:  r = (bi >= DATA_W) ? 0 : ai << bi;
    OP_SHR:  r = (bi >= DATA_W) ? 0 : ai >> bi;
    OP_SUB:  r = ai - bi;
    default: r = 0;
  endcase
  // Low bits only, wraps like the hardware
  return DATA_W'(r);
endfunction

// Unsigned compare packed as lt, gt, eq
function automatic logic [2:0] expect_cmp(
  input logic [DATA_W-1:0] a,
  input logic [DATA_W-1:0] b
);
  return {a < b, a > b, a == b};
endfunction

`endif

// ==== verification/tb_dpr_alu.sv ====
`timescale 1ns/1ps

module tb_dpr_alu;
  import dpr_pkg::*;

  `include "alu_model.svh"

  localparam int SEED      = 64481;
  localparam int NUM_ITEMS = 400;
  localparam int TIMEOUT   = 200;

  logic              clk;
  logic              rst_n_i;
  logic              in_valid_i;
  alu_op_e           in_op_i;
  logic [DATA_W-1:0] in_a_i;
  logic [DATA_W-1:0] in_b_i;
  logic              in_mux_sel_i;
  logic              decouple_i;
  logic              credit_o;
  logic              res_valid_o;
  logic [DATA_W-1:0] res_o;
  logic              comp_lt_o;
  logic              comp_gt_o;
  logic              comp_eq_o;
  logic              decouple_status_o;

  int                credits;
  int                sent;
  int                results;
  int                errors;
  int                dcpl_at;
  int                idle;
  bit                abort;
  logic [DATA_W-1:0] held;
  logic [DATA_W-1:0] exp_res_q [$];
  logic [2:0]        exp_cmp_q [$];
  logic [OP_W-1:0]   exp_op_q  [$];

  dpr_alu_top u_dut (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .in_valid_i        (in_valid_i),
    .in_op_i           (in_op_i),
    .in_a_i            (in_a_i),
    .in_b_i            (in_b_i),
    .in_mux_sel_i      (in_mux_sel_i),
    .decouple_i        (decouple_i),
    .credit_o          (credit_o),
    .res_valid_o       (res_valid_o),
    .res_o             (res_o),
    .comp_lt_o         (comp_lt_o),
    .comp_gt_o         (comp_gt_o),
    .comp_eq_o         (comp_eq_o),
    .decouple_status_o (decouple_status_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Called on a rising edge, spends one credit
  task automatic push_item();
    logic [OP_W-1:0]   op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic              sel;
    op  = OP_W'($urandom);
    a   = DATA_W'($urandom);
    // Small b often, to reach zero divisors and in-range shifts
    b   = (($urandom % 4) == 0) ? DATA_W'($urandom % 10) : DATA_W'($urandom);
    sel = 1'($urandom);
    exp_res_q.push_back(expect_result(op, a, b, sel, held));
    exp_cmp_q.push_back(expect_cmp(a, b));
    exp_op_q.push_back(op);
    if (op == OP_MUX) begin
      held = expect_result(op, a, b, sel, held);
    end
    credits = credits - 1;
    sent    = sent + 1;
    in_valid_i   <= 1'b1;
    in_op_i      <= alu_op_e'(op);
    in_a_i       <= a;
    in_b_i       <= b;
    in_mux_sel_i <= sel;
  endtask

  task automatic send_until(input int limit);
    idle = 0;
    while (sent < limit && !abort) begin
      @(posedge clk);
      if (credits > 0 && ($urandom % 4) != 0) begin
        push_item();
        idle = 0;
      end else begin
        in_valid_i <= 1'b0;
        idle = idle + 1;
        if (idle > TIMEOUT) begin
          $display("No credit came back within %0d cycles", TIMEOUT);
          errors = errors + 1;
          abort  = 1'b1;
        end
      end
    end
    @(posedge clk);
    in_valid_i <= 1'b0;
  endtask

  task automatic decouple_window();
    int wait_cnt;
    int hold_cycles;
    @(posedge clk);
    decouple_i <= 1'b1;
    wait_cnt = 0;
    @(negedge clk);
    while (!decouple_status_o && wait_cnt < TIMEOUT) begin
      @(negedge clk);
      wait_cnt = wait_cnt + 1;
    end
    if (!decouple_status_o) begin
      $display("Decouple status did not rise within %0d cycles", TIMEOUT);
      errors = errors + 1;
    end
    // Keep feeding the buffer while decoupled, the monitor watches for results
    hold_cycles = 5 + int'($urandom % 20);
    repeat (hold_cycles) begin
      @(posedge clk);
      if (credits > 0 && sent < NUM_ITEMS) begin
        push_item();
      end else begin
        in_valid_i <= 1'b0;
      end
    end
    @(posedge clk);
    in_valid_i <= 1'b0;
    decouple_i <= 1'b0;
  endtask

  always @(negedge clk) begin
    if (rst_n_i) begin
      if (credit_o !== res_valid_o) begin
        $display("Credit pulse and result valid disagree at %0t", $time);
        errors = errors + 1;
      end
      if (credit_o) begin
        credits = credits + 1;
        if (credits > CREDITS) begin
          $display("More credits returned than items sent at %0t", $time);
          errors = errors + 1;
        end
      end
      if (res_valid_o) begin
        results = results + 1;
        if (decouple_status_o) begin
          $display("Result appeared while decoupled at %0t", $time);
          errors = errors + 1;
        end
        if (exp_res_q.size() == 0) begin
          $display("Result appeared with no item outstanding at %0t", $time);
          errors = errors + 1;
        end else begin
          if (res_o !== exp_res_q[0]) begin
            $display("[ERROR] result op=%0d expected %0h actual %0h",
                     exp_op_q[0], exp_res_q[0], res_o);
            errors = errors + 1;
          end
          if ({comp_lt_o, comp_gt_o, comp_eq_o} !== exp_cmp_q[0]) begin
            $display("[ERROR] compare op=%0d expected %0b actual %0b",
                     exp_op_q[0], exp_cmp_q[0], {comp_lt_o, comp_gt_o, comp_eq_o});
            errors = errors + 1;
          end
          void'(exp_res_q.pop_front());
          void'(exp_cmp_q.pop_front());
          void'(exp_op_q.pop_front());
        end
      end
    end
  end

  initial begin
    void'($urandom(SEED));
    rst_n_i      = 1'b0;
    in_valid_i   = 1'b0;
    in_op_i      = OP_ADD;
    in_a_i       = '0;
    in_b_i       = '0;
    in_mux_sel_i = 1'b0;
    decouple_i   = 1'b0;
    credits      = CREDITS;
    sent         = 0;
    results      = 0;
    errors       = 0;
    abort        = 1'b0;
    held         = '0;
    repeat (10) @(posedge clk);
    rst_n_i <= 1'b1;
    dcpl_at = 100 + int'($urandom % 200);
    send_until(dcpl_at);
    decouple_window();
    send_until(NUM_ITEMS);
    idle = 0;
    while (exp_res_q.size() != 0 && idle < TIMEOUT) begin
      @(negedge clk);
      idle = idle + 1;
    end
    if (exp_res_q.size() != 0) begin
      $display("%0d results still outstanding after %0d cycles", exp_res_q.size(), TIMEOUT);
      errors = errors + 1;
    end
    repeat (2) @(negedge clk);
    if (credits != CREDITS) begin
      $display("[ERROR] credit_return expected %0d actual %0d", CREDITS, credits);
      errors = errors + 1;
    end
    $display("Errors: %0d, items sent: %0d, results checked: %0d", errors, sent, results);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+verification
hdl/dpr_pkg.sv
hdl/op_fifo.sv
hdl/arith_unit.sv
hdl/shift_select_unit.sv
hdl/rp_decoupler.sv
hdl/result_stage.sv
hdl/dpr_alu_top.sv
verification/tb_dpr_alu.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_dpr_alu -Mdir obj_dir
	./obj_dir/Vtb_dpr_alu > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
